/* logic/tlb_pkg.sv */
`default_nettype none

package tlb_pkg;

    // ------------------------------
    // entry field widths
    // ------------------------------
    localparam int tlb_virtpage_size = 20;
    localparam int tlb_physpage_size = 20;

    // bit 0 read, bit 1 write, bit 2 fixed
    localparam int tlb_perm_size = 3;
    localparam int tlb_perm_fixed_bit = 2;

    localparam int tlb_data_size = tlb_perm_size + tlb_physpage_size + tlb_virtpage_size;

    // ------------------------------
    // entry layout, high to low
    // ------------------------------
    typedef struct packed {
        logic [tlb_perm_size-1:0]     perm;
        logic [tlb_physpage_size-1:0] physpage;
        logic [tlb_virtpage_size-1:0] virtpage;
    } tlb_entry_t;

    // commands from the register block
    typedef enum logic [1:0] {
        tlb_cmd_write  = 2'd0,
        tlb_cmd_read   = 2'd1,
        tlb_cmd_delete = 2'd2,
        tlb_cmd_clear  = 2'd3
    } tlb_cmd_e;

    // result code, valid with done
    typedef enum logic [1:0] {
        tlb_err_none    = 2'd0,
        tlb_err_miss    = 2'd1,
        tlb_err_no_perm = 2'd2,
        tlb_err_full    = 2'd3
    } tlb_error_e;

endpackage

`default_nettype wire

/* logic/tlb_mem_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface tlb_mem_if #(
    parameter int TLB_ADDR_WIDTH = 5
);
    import tlb_pkg::*;

    logic                      en;
    logic                      we;
    logic [TLB_ADDR_WIDTH-1:0] addr;
    tlb_entry_t                wdata;
    tlb_entry_t                rdata;

    // wdata comes straight from the top level write port
    modport ctrl (output en, output we, output addr, input rdata);
    modport mem  (input en, input we, input addr, input wdata, output rdata);

endinterface

`default_nettype wire

/* logic/tlb_valid_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface tlb_valid_if #(
    parameter int TLB_ADDR_WIDTH = 5
);
    localparam int TLB_DEPTH = 1 << TLB_ADDR_WIDTH;

    // one-cycle pulses from the controller
    logic                      set;
    logic                      clr;
    logic [TLB_ADDR_WIDTH-1:0] idx;

    // tracker state and search results
    logic [TLB_DEPTH-1:0]      valid_bits;
    logic [TLB_ADDR_WIDTH-1:0] first_idx;
    logic [TLB_ADDR_WIDTH-1:0] last_idx;
    logic                      empty;

    modport ctrl (
        output set, output clr, output idx,
        input  valid_bits, input first_idx, input last_idx, input empty
    );

    modport tracker (
        input  set, input clr, input idx,
        output valid_bits, output first_idx, output last_idx, output empty
    );

endinterface

`default_nettype wire

/* logic/tlb_entry_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module tlb_entry_mem #(
    parameter int TLB_DEPTH = 32
) (
    input  logic   clk_i,
    input  logic   reset_n_i,
    tlb_mem_if.mem mem_o
);
    import tlb_pkg::*;

    localparam int TLB_ADDR_WIDTH = $clog2(TLB_DEPTH);

    logic [tlb_data_size-1:0] mem_q [TLB_DEPTH];
    tlb_entry_t               rdata_q;

    // storage array, single port
    always_ff @(posedge clk_i) begin
        if (mem_o.en && mem_o.we) begin
            mem_q[mem_o.addr] <= mem_o.wdata;
        end
    end

    // registered read, one cycle latency
    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            rdata_q <= '0;
        end else if (mem_o.en && !mem_o.we) begin
            rdata_q <= tlb_entry_t'(mem_q[mem_o.addr[TLB_ADDR_WIDTH-1:0]]);
        end
    end

    assign mem_o.rdata = rdata_q;

endmodule

`default_nettype wire

/* logic/tlb_valid_tracker.sv */
`timescale 1ns/1ns
`default_nettype none

module tlb_valid_tracker #(
    parameter int TLB_DEPTH = 32
) (
    input  logic           clk_i,
    input  logic           reset_n_i,
    tlb_valid_if.tracker   valid_o
);

    localparam int TLB_ADDR_WIDTH = $clog2(TLB_DEPTH);

    logic [TLB_DEPTH-1:0]      valid_q;
    logic [TLB_ADDR_WIDTH-1:0] first_idx;
    logic [TLB_ADDR_WIDTH-1:0] last_idx;

    // ------------------------------
    // valid bit register
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            valid_q <= '0;
        end else begin
            if (valid_o.set) begin
                valid_q[valid_o.idx] <= 1'b1;
            end
            if (valid_o.clr) begin
                valid_q[valid_o.idx] <= 1'b0;
            end
        end
    end

    // ------------------------------
    // priority search
    // ------------------------------

    // lowest set bit, the last hit of a downward scan wins
    always_comb begin
        first_idx = '0;
        for (int i = TLB_DEPTH - 1; i >= 0; i--) begin
            if (valid_q[i]) begin
                first_idx = TLB_ADDR_WIDTH'(i);
            end
        end
    end

    // highest set bit, the last hit of an upward scan wins
    always_comb begin
        last_idx = '0;
        for (int i = 0; i < TLB_DEPTH; i++) begin
            if (valid_q[i]) begin
                last_idx = TLB_ADDR_WIDTH'(i);
            end
        end
    end

    // both indices fall back to 0 on an empty table
    assign valid_o.valid_bits = valid_q;
    assign valid_o.first_idx  = first_idx;
    assign valid_o.last_idx   = last_idx;
    assign valid_o.empty      = ~|valid_q;

endmodule

`default_nettype wire

/* logic/tlb_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module tlb_ctrl #(
    parameter int TLB_DEPTH = 32
) (
    input  logic                clk_i,
    input  logic                reset_n_i,
    input  logic                en_i,
    input  tlb_pkg::tlb_cmd_e   cmd_i,
    input  tlb_pkg::tlb_entry_t req_i,
    output tlb_pkg::tlb_entry_t rdata_o,
    output logic                active_o,
    output logic                done_o,
    output tlb_pkg::tlb_error_e error_o,
    tlb_mem_if.ctrl             mem_o,
    tlb_valid_if.ctrl           valid_i
);
    import tlb_pkg::*;

    localparam int TLB_ADDR_WIDTH = $clog2(TLB_DEPTH);

    typedef enum logic [3:0] {
        st_idle,
        st_write_start,
        st_write_occup,
        st_write_overwrite,
        st_read_start,
        st_read_check,
        st_del_start,
        st_del_check,
        st_del_remove,
        st_clear_start,
        st_clear_check,
        st_clear_remove,
        st_finish
    } state_e;

    state_e                    state_q, state_d;
    logic [TLB_ADDR_WIDTH-1:0] addr_q, addr_d;
    logic                      probe_valid_q;
    tlb_entry_t                rdata_q, rdata_d;
    tlb_error_e                error_q, error_d;

    tlb_entry_t                entry;
    logic                      addr_valid;
    logic [TLB_ADDR_WIDTH-1:0] last_incr;
    logic [TLB_ADDR_WIDTH-1:0] cmp_dn_idx;
    logic [TLB_ADDR_WIDTH-1:0] cmp_up_idx;
    logic                      page_match;
    logic                      perm_match;

    assign entry      = mem_o.rdata;
    assign addr_valid = valid_i.valid_bits[addr_q];
    assign last_incr  = valid_i.last_idx + 1'b1;

    // the entry under compare lags the address by one slot
    assign cmp_dn_idx = addr_q + 1'b1;
    assign cmp_up_idx = addr_q - 1'b1;

    assign page_match = probe_valid_q && (entry.virtpage == req_i.virtpage);
    // only read and write take part in the permission check
    assign perm_match = |(entry.perm[1:0] & req_i.perm[1:0]);

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            state_q       <= st_idle;
            addr_q        <= '0;
            probe_valid_q <= 1'b0;
            rdata_q       <= '0;
            error_q       <= tlb_err_none;
        end else begin
            state_q       <= state_d;
            addr_q        <= addr_d;
            probe_valid_q <= addr_valid;
            rdata_q       <= rdata_d;
            error_q       <= error_d;
        end
    end

    always_comb begin
        state_d       = state_q;
        addr_d        = addr_q;
        rdata_d       = rdata_q;
        error_d       = error_q;
        mem_o.en      = 1'b0;
        mem_o.we      = 1'b0;
        valid_i.set   = 1'b0;
        valid_i.clr   = 1'b0;

        case (state_q)
            st_idle: begin
                if (en_i) begin
                    error_d = tlb_err_none;
                    case (cmd_i)
                        tlb_cmd_write: begin
                            addr_d  = valid_i.empty ? '0 : last_incr;
                            state_d = st_write_start;
                        end
                        tlb_cmd_read: begin
                            addr_d  = valid_i.last_idx;
                            state_d = st_read_start;
                        end
                        tlb_cmd_delete: begin
                            addr_d  = valid_i.last_idx;
                            state_d = st_del_start;
                        end
                        tlb_cmd_clear: begin
                            addr_d  = valid_i.first_idx;
                            state_d = st_clear_start;
                        end
                    endcase
                end
            end

            // ------------------------------
            // write
            // ------------------------------
            st_write_start: begin
                mem_o.en = 1'b1;
                if (!addr_valid) begin
                    mem_o.we    = 1'b1;
                    valid_i.set = 1'b1;
                    state_d     = st_finish;
                end else begin
                    // slot taken, look for something to evict
                    addr_d  = addr_q + 1'b1;
                    state_d = st_write_occup;
                end
            end

            st_write_occup: begin
                // next slot is fetched while this one is checked
                mem_o.en = 1'b1;
                if (entry.perm[tlb_perm_fixed_bit]) begin
                    if (addr_q == last_incr) begin
                        // came all the way round, nothing to evict
                        error_d = tlb_err_full;
                        state_d = st_finish;
                    end else if (addr_valid) begin
                        addr_d = addr_q + 1'b1;
                    end else begin
                        state_d = st_write_overwrite;
                    end
                end else begin
                    addr_d  = cmp_up_idx;
                    state_d = st_write_overwrite;
                end
            end

            st_write_overwrite: begin
                mem_o.en    = 1'b1;
                mem_o.we    = 1'b1;
                valid_i.set = 1'b1;
                state_d     = st_finish;
            end

            // ------------------------------
            // read, highest slot first
            // ------------------------------
            st_read_start: begin
                mem_o.en = 1'b1;
                if (addr_valid) begin
                    addr_d  = addr_q - 1'b1;
                    state_d = st_read_check;
                end else begin
                    error_d = tlb_err_miss;
                    state_d = st_finish;
                end
            end

            st_read_check: begin
                rdata_d  = entry;
                mem_o.en = addr_valid;
                if (page_match) begin
                    error_d = perm_match ? tlb_err_none : tlb_err_no_perm;
                    state_d = st_finish;
                end else if (cmp_dn_idx > valid_i.first_idx) begin
                    addr_d = addr_q - 1'b1;
                end else begin
                    error_d = tlb_err_miss;
                    state_d = st_finish;
                end
            end

            // ------------------------------
            // delete, same walk as read
            // ------------------------------
            st_del_start: begin
                mem_o.en = 1'b1;
                if (addr_valid) begin
                    addr_d  = addr_q - 1'b1;
                    state_d = st_del_check;
                end else begin
                    error_d = tlb_err_miss;
                    state_d = st_finish;
                end
            end

            st_del_check: begin
                mem_o.en = addr_valid;
                if (page_match) begin
                    addr_d  = cmp_dn_idx;
                    state_d = st_del_remove;
                end else if (cmp_dn_idx > valid_i.first_idx) begin
                    addr_d = addr_q - 1'b1;
                end else begin
                    error_d = tlb_err_miss;
                    state_d = st_finish;
                end
            end

            st_del_remove: begin
                valid_i.clr = 1'b1;
                state_d     = st_finish;
            end

            // ------------------------------
            // clear, lowest slot first
            // ------------------------------
            st_clear_start: begin
                mem_o.en = 1'b1;
                addr_d   = addr_q + 1'b1;
                state_d  = st_clear_check;
            end

            st_clear_check: begin
                mem_o.en = addr_valid;
                if (probe_valid_q && !entry.perm[tlb_perm_fixed_bit]) begin
                    addr_d  = cmp_up_idx;
                    state_d = st_clear_remove;
                end else if (cmp_up_idx < valid_i.last_idx) begin
                    addr_d = addr_q + 1'b1;
                end else begin
                    state_d = st_finish;
                end
            end

            // resume the walk just above the removed slot
            st_clear_remove: begin
                valid_i.clr = 1'b1;
                addr_d      = addr_q + 1'b1;
                state_d     = st_clear_start;
            end

            st_finish: begin
                state_d = st_idle;
            end

            default: begin
                state_d = st_idle;
            end
        endcase
    end

    assign valid_i.idx = addr_q;
    assign mem_o.addr  = addr_q;

    assign rdata_o  = rdata_q;
    assign active_o = (state_q != st_idle);
    assign done_o   = (state_q == st_finish);
    assign error_o  = error_q;

endmodule

`default_nettype wire

/* logic/tlb_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tlb_top #(
    parameter int TLB_DEPTH = 32
) (
    input  logic                clk_i,
    input  logic                reset_n_i,

    // command from the register block
    input  logic                tlb_en_i,
    input  tlb_pkg::tlb_cmd_e   tlb_cmd_i,
    input  tlb_pkg::tlb_entry_t tlb_wdata_i,

    // result, valid with done
    output tlb_pkg::tlb_entry_t tlb_rdata_o,
    output logic                tlb_active_o,
    output logic                tlb_done_o,
    output tlb_pkg::tlb_error_e tlb_error_o
);

    localparam int TLB_ADDR_WIDTH = $clog2(TLB_DEPTH);

    tlb_mem_if   #(.TLB_ADDR_WIDTH(TLB_ADDR_WIDTH)) mem_if ();
    tlb_valid_if #(.TLB_ADDR_WIDTH(TLB_ADDR_WIDTH)) valid_if ();

    // the register block holds wdata stable for the whole command
    assign mem_if.wdata = tlb_wdata_i;

    tlb_ctrl #(
        .TLB_DEPTH (TLB_DEPTH)
    ) i_tlb_ctrl (
        .clk_i     (clk_i),
        .reset_n_i (reset_n_i),
        .en_i      (tlb_en_i),
        .cmd_i     (tlb_cmd_i),
        .req_i     (tlb_wdata_i),
        .rdata_o   (tlb_rdata_o),
        .active_o  (tlb_active_o),
        .done_o    (tlb_done_o),
        .error_o   (tlb_error_o),
        .mem_o     (mem_if.ctrl),
        .valid_i   (valid_if.ctrl)
    );

    tlb_entry_mem #(
        .TLB_DEPTH (TLB_DEPTH)
    ) i_tlb_entry_mem (
        .clk_i     (clk_i),
        .reset_n_i (reset_n_i),
        .mem_o     (mem_if.mem)
    );

    tlb_valid_tracker #(
        .TLB_DEPTH (TLB_DEPTH)
    ) i_tlb_valid_tracker (
        .clk_i     (clk_i),
        .reset_n_i (reset_n_i),
        .valid_o   (valid_if.tracker)
    );

endmodule

`default_nettype wire

/* tests/tlb_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module tlb_tb;
    import tlb_pkg::*;

    localparam int TB_DEPTH   = 8;
    localparam int CLK_PERIOD = 8;
    localparam int NUM_TESTS  = 6;

    logic       clk;
    logic       reset_n;
    logic       tlb_en;
    tlb_cmd_e   tlb_cmd;
    tlb_entry_t tlb_wdata;
    tlb_entry_t tlb_rdata;
    logic       tlb_active;
    logic       tlb_done;
    tlb_error_e tlb_error;

    // expected result of the command in flight
    tlb_error_e exp_error;
    tlb_entry_t exp_rdata;
    logic       check_rdata;

    // reference table, one slot per entry
    logic       ref_valid [TB_DEPTH];
    tlb_entry_t ref_entry [TB_DEPTH];

    logic [tlb_virtpage_size-1:0] used_pages [$];
    tlb_entry_t                   kept [$];
    logic [tlb_virtpage_size-1:0] page;

    int seed = 44143;
    int error_count;
    int errors_at_start;
    int pass_count;
    int fail_count;
    int test_num;
    int accept_count;
    int done_count;
    int done_before;

    tlb_top #(
        .TLB_DEPTH    (TB_DEPTH)
    ) i_tlb_top (
        .clk_i        (clk),
        .reset_n_i    (reset_n),
        .tlb_en_i     (tlb_en),
        .tlb_cmd_i    (tlb_cmd),
        .tlb_wdata_i  (tlb_wdata),
        .tlb_rdata_o  (tlb_rdata),
        .tlb_active_o (tlb_active),
        .tlb_done_o   (tlb_done),
        .tlb_error_o  (tlb_error)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // commands taken and done pulses seen
    always @(posedge clk) begin
        if (reset_n && tlb_en && !tlb_active) begin
            accept_count <= accept_count + 1;
        end
        if (reset_n && tlb_done) begin
            done_count <= done_count + 1;
        end
    end

    // ------------------------------
    // checks
    // ------------------------------
    assert property (@(posedge clk) disable iff (!reset_n)
        tlb_done |-> tlb_active ##1 !tlb_done)
    else begin
        $display("** Error: %0t ns: done longer than one cycle or outside active", $time);
        error_count++;
    end

    assert property (@(posedge clk) disable iff (!reset_n)
        $fell(tlb_active) |-> $past(tlb_done))
    else begin
        $display("** Error: %0t ns: active dropped without a done pulse", $time);
        error_count++;
    end

    assert property (@(posedge clk) disable iff (!reset_n)
        tlb_done |-> accept_count == done_count + 1)
    else begin
        $display("** Error: %0t ns: done count %0d for %0d accepted commands",
                 $time, done_count + 1, accept_count);
        error_count++;
    end

    assert property (@(posedge clk) disable iff (!reset_n)
        tlb_done |-> tlb_error == exp_error)
    else begin
        $display("** Error: %0t ns: error code %s, expected %s",
                 $time, tlb_error.name(), exp_error.name());
        error_count++;
    end

    assert property (@(posedge clk) disable iff (!reset_n)
        tlb_done && check_rdata |-> tlb_rdata == exp_rdata)
    else begin
        $display("** Error: %0t ns: rdata %h, expected %h", $time, tlb_rdata, exp_rdata);
        error_count++;
    end

    // ------------------------------
    // helpers
    // ------------------------------
    function automatic logic [tlb_virtpage_size-1:0] fresh_page();
        logic [tlb_virtpage_size-1:0] cand;
        bit                           dup;
        do begin
            cand = tlb_virtpage_size'($random(seed));
            dup  = 1'b0;
            foreach (used_pages[i]) begin
                if (used_pages[i] == cand) begin
                    dup = 1'b1;
                end
            end
        end while (dup);
        used_pages.push_back(cand);
        return cand;
    endfunction

    function automatic tlb_entry_t make_entry(input logic fixed);
        tlb_entry_t e;
        e.virtpage                 = fresh_page();
        e.physpage                 = tlb_physpage_size'($random(seed));
        e.perm[1:0]                = 2'(1 + ({$random(seed)} % 3));
        e.perm[tlb_perm_fixed_bit] = fixed;
        return e;
    endfunction

    // highest valid slot holding the page, -1 if none
    function automatic int find_slot(input logic [tlb_virtpage_size-1:0] vpage);
        for (int i = TB_DEPTH - 1; i >= 0; i--) begin
            if (ref_valid[i] && ref_entry[i].virtpage == vpage) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic int highest_slot();
        for (int i = TB_DEPTH - 1; i >= 0; i--) begin
            if (ref_valid[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        #1;
        reset_n = 1'b0;
        tlb_en  = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        reset_n = 1'b1;
        for (int i = 0; i < TB_DEPTH; i++) begin
            ref_valid[i] = 1'b0;
        end
    endtask

    // one command, returns one cycle after its done pulse
    task automatic issue(input tlb_cmd_e cmd, input tlb_entry_t data, input bit hold_en);
        @(posedge clk);
        #1;
        tlb_en    = 1'b1;
        tlb_cmd   = cmd;
        tlb_wdata = data;
        @(posedge clk);
        #1;
        if (!hold_en) begin
            tlb_en = 1'b0;
        end
        while (!tlb_done) begin
            @(posedge clk);
            #1;
        end
        // a held enable stays up through the done cycle
        @(posedge clk);
        #1;
        tlb_en = 1'b0;
    endtask

    task automatic write_entry(input tlb_entry_t e, input bit hold_en);
        int top;
        top         = highest_slot();
        check_rdata = 1'b0;
        // a table full of fixed entries rejects the write
        if (top == TB_DEPTH - 1) begin
            exp_error = tlb_err_full;
        end else begin
            exp_error            = tlb_err_none;
            ref_valid[top + 1]   = 1'b1;
            ref_entry[top + 1]   = e;
        end
        issue(tlb_cmd_write, e, hold_en);
    endtask

    task automatic read_page(input logic [tlb_virtpage_size-1:0] vpage,
                             input logic [1:0] rw, input bit hold_en);
        tlb_entry_t req;
        int         slot;
        req           = '0;
        req.virtpage  = vpage;
        req.perm[1:0] = rw;
        slot          = find_slot(vpage);
        check_rdata   = 1'b0;
        if (slot < 0) begin
            exp_error = tlb_err_miss;
        end else if ((ref_entry[slot].perm[1:0] & rw) == 2'b00) begin
            exp_error = tlb_err_no_perm;
        end else begin
            exp_error   = tlb_err_none;
            exp_rdata   = ref_entry[slot];
            check_rdata = 1'b1;
        end
        issue(tlb_cmd_read, req, hold_en);
    endtask

    task automatic delete_page(input logic [tlb_virtpage_size-1:0] vpage, input bit hold_en);
        tlb_entry_t req;
        int         slot;
        req          = '0;
        req.virtpage = vpage;
        slot         = find_slot(vpage);
        check_rdata  = 1'b0;
        if (slot < 0) begin
            exp_error = tlb_err_miss;
        end else begin
            exp_error       = tlb_err_none;
            ref_valid[slot] = 1'b0;
        end
        issue(tlb_cmd_delete, req, hold_en);
    endtask

    task automatic clear_table(input bit hold_en);
        check_rdata = 1'b0;
        exp_error   = tlb_err_none;
        for (int i = 0; i < TB_DEPTH; i++) begin
            if (!ref_entry[i].perm[tlb_perm_fixed_bit]) begin
                ref_valid[i] = 1'b0;
            end
        end
        issue(tlb_cmd_clear, '0, hold_en);
    endtask

    task automatic report_test(input string name);
        test_num++;
        if (error_count == errors_at_start) begin
            pass_count++;
            $display("test %0d %s: pass", test_num, name);
        end else begin
            fail_count++;
            $display("test %0d %s: fail with %0d errors", test_num, name,
                     error_count - errors_at_start);
        end
        errors_at_start = error_count;
    endtask

    // ------------------------------
    // watchdog
    // ------------------------------
    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", NUM_TESTS * 200);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        reset_n     = 1'b0;
        tlb_en      = 1'b0;
        tlb_cmd     = tlb_cmd_read;
        tlb_wdata   = '0;
        exp_error   = tlb_err_none;
        exp_rdata   = '0;
        check_rdata = 1'b0;
        for (int i = 0; i < TB_DEPTH; i++) begin
            ref_valid[i] = 1'b0;
            ref_entry[i] = '0;
        end

        // reset state, then reads of an empty table
        apply_reset();
        assert (!tlb_active && !tlb_done && tlb_error == tlb_err_none && tlb_rdata == '0)
        else begin
            $display("** Error: %0t ns: outputs not idle after reset", $time);
            error_count++;
        end
        read_page(fresh_page(), 2'b11, 1'b0);
        read_page(fresh_page(), 2'b01, 1'b0);
        report_test("reset state");

        // five entries into slots 0 to 4
        for (int i = 0; i < 5; i++) begin
            write_entry(make_entry(1'b0), 1'b0);
        end
        for (int i = 0; i < 5; i++) begin
            read_page(ref_entry[i].virtpage, 2'b11, 1'b0);
        end
        read_page(ref_entry[0].virtpage, ~ref_entry[0].perm[1:0], 1'b0);
        read_page(ref_entry[3].virtpage, ~ref_entry[3].perm[1:0], 1'b0);
        report_test("write then read");

        // delete from the middle leaves a hole
        page = ref_entry[2].virtpage;
        delete_page(page, 1'b0);
        read_page(page, 2'b11, 1'b0);
        delete_page(fresh_page(), 1'b0);
        for (int i = 0; i < TB_DEPTH; i++) begin
            if (ref_valid[i]) begin
                read_page(ref_entry[i].virtpage, 2'b11, 1'b0);
            end
        end
        report_test("delete");

        write_entry(make_entry(1'b1), 1'b0);
        write_entry(make_entry(1'b0), 1'b0);
        write_entry(make_entry(1'b1), 1'b0);
        kept.delete();
        for (int i = 0; i < TB_DEPTH; i++) begin
            if (ref_valid[i]) begin
                kept.push_back(ref_entry[i]);
            end
        end
        clear_table(1'b0);
        foreach (kept[i]) begin
            read_page(kept[i].virtpage, 2'b11, 1'b0);
        end
        report_test("clear");

        // full table of fixed entries
        apply_reset();
        for (int i = 0; i < TB_DEPTH; i++) begin
            write_entry(make_entry(1'b1), 1'b0);
        end
        page = fresh_page();
        write_entry('{perm: 3'b111, physpage: '0, virtpage: page}, 1'b0);
        for (int i = 0; i < TB_DEPTH; i++) begin
            read_page(ref_entry[i].virtpage, 2'b11, 1'b0);
        end
        read_page(page, 2'b11, 1'b0);
        report_test("full table");

        // enable held high through every command
        done_before = done_count;
        write_entry(make_entry(1'b1), 1'b1);
        read_page(ref_entry[5].virtpage, 2'b11, 1'b1);
        read_page(fresh_page(), 2'b11, 1'b1);
        delete_page(ref_entry[3].virtpage, 1'b1);
        clear_table(1'b1);
        assert (done_count - done_before == 5)
        else begin
            $display("** Error: %0t ns: %0d done pulses for 5 commands",
                     $time, done_count - done_before);
            error_count++;
        end
        report_test("done framing");

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
logic/tlb_pkg.sv
logic/tlb_mem_if.sv
logic/tlb_valid_if.sv
logic/tlb_entry_mem.sv
logic/tlb_valid_tracker.sv
logic/tlb_ctrl.sv
logic/tlb_top.sv
tests/tlb_tb.sv

/* Bender.yml */
package:
  name: tlb

sources:
  - logic/tlb_pkg.sv
  - logic/tlb_mem_if.sv
  - logic/tlb_valid_if.sv
  - logic/tlb_entry_mem.sv
  - logic/tlb_valid_tracker.sv
  - logic/tlb_ctrl.sv
  - logic/tlb_top.sv
  - target: test
    files:
      - tests/tlb_tb.sv
